// File: common/id_stage_consts.svh
`ifndef ID_STAGE_CONSTS_SVH
`define ID_STAGE_CONSTS_SVH

`define XLEN  32
`define NREGS 32

// base opcodes
`define OP_IMM    7'b0010011
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_OP     7'b0110011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011

// funct3 codes
`define F3_BEQ     3'b000
`define F3_BNE     3'b001
`define F3_BLT     3'b100
`define F3_BGE     3'b101
`define F3_BLTU    3'b110
`define F3_BGEU    3'b111
`define F3_SRL_SRA 3'b101

`define NOP_IR 32'h00000013 // addi x0,x0,0
`define NOP_PC 32'h00000000

`endif

// File: common/id_stage_pkg.sv
`include "id_stage_consts.svh"

package id_stage_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       regaddr_t;
    typedef logic [6:0]       opcode_t;
    typedef logic [2:0]       funct3_t;
    typedef logic [4:0]       alu_mode_t; // {funct7[0], funct7[5], funct3}
    typedef logic [2:0]       ma_size_t;  // funct3 of load/store

    // where the next pc comes from
    typedef enum logic [1:0] {
        PC_NEXT     = 2'b00,
        PC_JUMP_REL = 2'b01,
        PC_JUMP_ABS = 2'b10,
        PC_BRANCH   = 2'b11
    } pc_mode_t;

    typedef enum logic [1:0] {
        OP1_ZERO = 2'b00,
        OP1_RS1  = 2'b01,
        OP1_IMMU = 2'b10
    } alu_op1_sel_t;

    typedef enum logic [2:0] {
        OP2_ZERO = 3'b000,
        OP2_RS2  = 3'b001,
        OP2_IMMI = 3'b010,
        OP2_IMMS = 3'b011,
        OP2_PC   = 3'b100
    } alu_op2_sel_t;

    typedef enum logic [1:0] {
        MA_NONE  = 2'b00,
        MA_LOAD  = 2'b01,
        MA_STORE = 2'b10
    } ma_mode_t;

    typedef enum logic [1:0] {
        WB_NONE = 2'b00,
        WB_ALU  = 2'b01,
        WB_MEM  = 2'b10,
        WB_PC4  = 2'b11
    } wb_src_t;

endpackage

// File: decode/instr_decoder.sv
`timescale 1ns/10ps
`include "id_stage_consts.svh"

module instr_decoder
    import id_stage_pkg::*;
    (
        input  word_t        ir_i,
        output regaddr_t     rs1_o,
        output regaddr_t     rs2_o,
        output regaddr_t     rd_o,
        output funct3_t      funct3_o,
        output word_t        imm_i_o,
        output word_t        imm_s_o,
        output word_t        imm_b_o,
        output word_t        imm_u_o,
        output word_t        imm_j_o,
        output pc_mode_t     pc_mode_o,
        output alu_op1_sel_t op1_sel_o,
        output alu_op2_sel_t op2_sel_o,
        output alu_mode_t    alu_mode_o,
        output ma_mode_t     ma_mode_o,
        output ma_size_t     ma_size_o,
        output wb_src_t      wb_src_o,
        output logic         illegal_o
    );

    localparam alu_mode_t ALU_ADD = 5'b00000;

    opcode_t     opcode;
    logic [6:0]  funct7;
    alu_mode_t   alu_mode3;
    alu_mode_t   alu_mode7;

    // field split
    assign opcode   = ir_i[6:0];
    assign rd_o     = ir_i[11:7];
    assign funct3_o = ir_i[14:12];
    assign rs1_o    = ir_i[19:15];
    assign rs2_o    = ir_i[24:20];
    assign funct7   = ir_i[31:25];

    // sign-extended immediates
    assign imm_i_o = {{20{ir_i[31]}}, ir_i[31:20]};
    assign imm_s_o = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
    assign imm_b_o = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
    assign imm_u_o = {ir_i[31:12], 12'b0};
    assign imm_j_o = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

    assign alu_mode7 = {funct7[0], funct7[5], funct3_o};
    assign alu_mode3 = {2'b00, funct3_o};

    always_comb begin
        // defaults describe a harmless no-op
        pc_mode_o  = PC_NEXT;
        op1_sel_o  = OP1_ZERO;
        op2_sel_o  = OP2_ZERO;
        alu_mode_o = ALU_ADD;
        ma_mode_o  = MA_NONE;
        ma_size_o  = 3'b000;
        wb_src_o   = WB_NONE;
        illegal_o  = 1'b0;

        casez ({funct7, funct3_o, opcode})
            {7'b0?00000, `F3_SRL_SRA, `OP_IMM}: begin // srli / srai need funct7
                op1_sel_o  = OP1_RS1;
                op2_sel_o  = OP2_IMMI;
                alu_mode_o = alu_mode7;
                wb_src_o   = WB_ALU;
            end
            {7'b???????, 3'b???, `OP_IMM}: begin
                op1_sel_o  = OP1_RS1;
                op2_sel_o  = OP2_IMMI;
                alu_mode_o = alu_mode3;
                wb_src_o   = WB_ALU;
            end
            {7'b???????, 3'b???, `OP_LUI}: begin
                op1_sel_o = OP1_IMMU; // imm_u + 0
                wb_src_o  = WB_ALU;
            end
            {7'b???????, 3'b???, `OP_AUIPC}: begin
                op1_sel_o = OP1_IMMU;
                op2_sel_o = OP2_PC;
                wb_src_o  = WB_ALU;
            end
            {7'b???????, 3'b???, `OP_OP}: begin
                op1_sel_o  = OP1_RS1;
                op2_sel_o  = OP2_RS2;
                alu_mode_o = alu_mode7;
                wb_src_o   = WB_ALU;
            end
            {7'b???????, 3'b???, `OP_JAL}: begin
                pc_mode_o = PC_JUMP_REL;
                wb_src_o  = WB_PC4;
            end
            {7'b???????, 3'b???, `OP_JALR}: begin
                pc_mode_o = PC_JUMP_ABS;
                wb_src_o  = WB_PC4;
            end
            {7'b???????, `F3_BEQ,  `OP_BRANCH},
            {7'b???????, `F3_BNE,  `OP_BRANCH},
            {7'b???????, `F3_BLT,  `OP_BRANCH},
            {7'b???????, `F3_BGE,  `OP_BRANCH},
            {7'b???????, `F3_BLTU, `OP_BRANCH},
            {7'b???????, `F3_BGEU, `OP_BRANCH}: begin
                pc_mode_o = PC_BRANCH;
            end
            {7'b???????, 3'b???, `OP_LOAD}: begin
                op1_sel_o = OP1_RS1;
                op2_sel_o = OP2_IMMI;
                ma_mode_o = MA_LOAD;
                ma_size_o = ma_size_t'(funct3_o);
                wb_src_o  = WB_MEM;
            end
            {7'b???????, 3'b???, `OP_STORE}: begin
                op1_sel_o = OP1_RS1;
                op2_sel_o = OP2_IMMS;
                ma_mode_o = MA_STORE;
                ma_size_o = ma_size_t'(funct3_o);
            end
            default: illegal_o = 1'b1; // raises halt downstream
        endcase
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/10ps
`include "id_stage_consts.svh"

module regfile
    import id_stage_pkg::*;
    (
        input  logic     clk_i,
        input  regaddr_t rd1_addr_i,
        input  regaddr_t rd2_addr_i,
        output word_t    rd1_data_o,
        output word_t    rd2_data_o,
        input  regaddr_t wr_addr_i,
        input  word_t    wr_data_i,
        input  logic     wr_en_i
    );

    word_t mem [`NREGS];

    // x0 is never written
    always_ff @(posedge clk_i) begin
        if (wr_en_i && wr_addr_i != 5'd0) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // asynchronous reads, x0 hardwired to zero
    assign rd1_data_o = (rd1_addr_i == 5'd0) ? '0 : mem[rd1_addr_i];
    assign rd2_data_o = (rd2_addr_i == 5'd0) ? '0 : mem[rd2_addr_i];

endmodule

// File: verilog/operand_unit.sv
`timescale 1ns/10ps

module operand_unit
    import id_stage_pkg::*;
    (
        input  logic         clk_i,
        input  word_t        pc_i,
        input  logic         valid_i,
        input  logic         reset_i,
        input  regaddr_t     rs1_i,
        input  regaddr_t     rs2_i,
        input  funct3_t      funct3_i,
        input  word_t        imm_i_i,
        input  word_t        imm_s_i,
        input  word_t        imm_b_i,
        input  word_t        imm_u_i,
        input  word_t        imm_j_i,
        input  pc_mode_t     pc_mode_i,
        input  alu_op1_sel_t op1_sel_i,
        input  alu_op2_sel_t op2_sel_i,
        input  regaddr_t     wb_addr_i,
        input  word_t        wb_data_i,
        input  logic         wb_valid_i,
        output word_t        alu_op1_o,
        output word_t        alu_op2_o,
        output word_t        rs2_val_o,
        output word_t        jmp_addr_o,
        output logic         jmp_valid_o
    );

    word_t rd1_data;
    word_t rd2_data;
    word_t rs1_val;
    logic  taken;

    regfile u_regfile (
        .clk_i      (clk_i),
        .rd1_addr_i (rs1_i),
        .rd2_addr_i (rs2_i),
        .rd1_data_o (rd1_data),
        .rd2_data_o (rd2_data),
        .wr_addr_i  (wb_addr_i),
        .wr_data_i  (wb_data_i),
        .wr_en_i    (wb_valid_i)
    );

    // same-cycle write-back wins over the stored value
    assign rs1_val   = (wb_valid_i && rs1_i != 5'd0 && wb_addr_i == rs1_i) ? wb_data_i : rd1_data;
    assign rs2_val_o = (wb_valid_i && rs2_i != 5'd0 && wb_addr_i == rs2_i) ? wb_data_i : rd2_data;

    always_comb begin
        case (op1_sel_i)
            OP1_RS1:  alu_op1_o = rs1_val;
            OP1_IMMU: alu_op1_o = imm_u_i;
            default:  alu_op1_o = '0;
        endcase

        case (op2_sel_i)
            OP2_RS2:  alu_op2_o = rs2_val_o;
            OP2_IMMI: alu_op2_o = imm_i_i;
            OP2_IMMS: alu_op2_o = imm_s_i;
            OP2_PC:   alu_op2_o = pc_i;
            default:  alu_op2_o = '0;
        endcase
    end

    // funct3[2:1] picks the compare, funct3[0] negates it
    always_comb begin
        case (funct3_i[2:1])
            2'b00:   taken = (rs1_val == rs2_val_o);
            2'b10:   taken = ($signed(rs1_val) < $signed(rs2_val_o));
            2'b11:   taken = (rs1_val < rs2_val_o);
            default: taken = 1'b0;
        endcase
        taken = taken ^ funct3_i[0];
    end

    always_comb begin
        jmp_valid_o = 1'b0;
        jmp_addr_o  = '0;
        case (pc_mode_i)
            PC_JUMP_REL: begin
                jmp_valid_o = 1'b1;
                jmp_addr_o  = pc_i + imm_j_i;
            end
            PC_JUMP_ABS: begin
                jmp_valid_o = 1'b1;
                jmp_addr_o  = rs1_val + imm_i_i;
            end
            PC_BRANCH: begin
                jmp_valid_o = taken;
                jmp_addr_o  = pc_i + imm_b_i;
            end
            default: ;
        endcase
        if (reset_i || !valid_i) begin
            jmp_valid_o = 1'b0; // no redirect without an instruction
        end
    end

endmodule

// File: verilog/id_output_reg.sv
`timescale 1ns/10ps
`include "id_stage_consts.svh"

module id_output_reg
    import id_stage_pkg::*;
    (
        input  logic      clk_i,
        input  logic      reset_i,
        input  logic      valid_i,
        input  logic      stall_i,
        input  word_t     pc_i,
        input  word_t     ir_i,
        input  regaddr_t  rd_i,
        input  logic      illegal_i,
        input  word_t     alu_op1_i,
        input  word_t     alu_op2_i,
        input  word_t     rs2_val_i,
        input  alu_mode_t alu_mode_i,
        input  ma_mode_t  ma_mode_i,
        input  ma_size_t  ma_size_i,
        input  wb_src_t   wb_src_i,
        output word_t     pc_o,
        output word_t     ir_o,
        output word_t     alu_op1_o,
        output word_t     alu_op2_o,
        output alu_mode_t alu_mode_o,
        output ma_mode_t  ma_mode_o,
        output ma_size_t  ma_size_o,
        output word_t     ma_data_o,
        output wb_src_t   wb_src_o,
        output word_t     wb_pc4_o,
        output logic      wb_valid_o,
        output logic      halt_o
    );

    always_ff @(posedge clk_i) begin
        if (reset_i || (!stall_i && !valid_i)) begin
            // bubble, addi x0,x0,0 with no side effects
            pc_o       <= `NOP_PC;
            ir_o       <= `NOP_IR;
            alu_op1_o  <= '0;
            alu_op2_o  <= '0;
            alu_mode_o <= '0;
            ma_mode_o  <= MA_NONE;
            ma_size_o  <= '0;
            ma_data_o  <= '0;
            wb_src_o   <= WB_NONE;
            wb_pc4_o   <= '0;
            wb_valid_o <= 1'b0;
            halt_o     <= 1'b0;
        end else if (!stall_i) begin
            pc_o       <= pc_i;
            ir_o       <= ir_i;
            alu_op1_o  <= alu_op1_i;
            alu_op2_o  <= alu_op2_i;
            alu_mode_o <= alu_mode_i;
            ma_mode_o  <= ma_mode_i;
            ma_size_o  <= ma_size_i;
            ma_data_o  <= rs2_val_i; // store data
            wb_src_o   <= wb_src_i;
            wb_pc4_o   <= pc_i + 32'd4; // link value for jal/jalr
            wb_valid_o <= (wb_src_i != WB_NONE) && (rd_i != 5'd0);
            halt_o     <= illegal_i;
        end
        // stall holds everything
    end

endmodule

// File: verilog/id_stage.sv
`timescale 1ns/10ps

module id_stage
    import id_stage_pkg::*;
    (
        input  logic      clk_i,
        input  logic      reset_i,
        input  word_t     pc_i,
        input  word_t     ir_i,
        input  logic      valid_i,
        input  regaddr_t  wb_addr_i,
        input  word_t     wb_data_i,
        input  logic      wb_valid_i,
        input  logic      stall_i,
        output logic      ready_o,
        output word_t     jmp_addr_o,
        output logic      jmp_valid_o,
        output word_t     pc_o,
        output word_t     ir_o,
        output word_t     alu_op1_o,
        output word_t     alu_op2_o,
        output alu_mode_t alu_mode_o,
        output ma_mode_t  ma_mode_o,
        output ma_size_t  ma_size_o,
        output word_t     ma_data_o,
        output wb_src_t   wb_src_o,
        output word_t     wb_pc4_o,
        output logic      wb_valid_o,
        output logic      halt_o
    );

    regaddr_t     rs1, rs2, rd;
    funct3_t      funct3;
    word_t        imm_i, imm_s, imm_b, imm_u, imm_j;
    pc_mode_t     pc_mode;
    alu_op1_sel_t op1_sel;
    alu_op2_sel_t op2_sel;
    alu_mode_t    alu_mode;
    ma_mode_t     ma_mode;
    ma_size_t     ma_size;
    wb_src_t      wb_src;
    logic         illegal;
    word_t        alu_op1, alu_op2, rs2_val;

    assign ready_o = !stall_i; // no internal hazards left

    instr_decoder u_decoder (
        .ir_i       (ir_i),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .rd_o       (rd),
        .funct3_o   (funct3),
        .imm_i_o    (imm_i),
        .imm_s_o    (imm_s),
        .imm_b_o    (imm_b),
        .imm_u_o    (imm_u),
        .imm_j_o    (imm_j),
        .pc_mode_o  (pc_mode),
        .op1_sel_o  (op1_sel),
        .op2_sel_o  (op2_sel),
        .alu_mode_o (alu_mode),
        .ma_mode_o  (ma_mode),
        .ma_size_o  (ma_size),
        .wb_src_o   (wb_src),
        .illegal_o  (illegal)
    );

    operand_unit u_operands (
        .clk_i       (clk_i),
        .pc_i        (pc_i),
        .valid_i     (valid_i),
        .reset_i     (reset_i),
        .rs1_i       (rs1),
        .rs2_i       (rs2),
        .funct3_i    (funct3),
        .imm_i_i     (imm_i),
        .imm_s_i     (imm_s),
        .imm_b_i     (imm_b),
        .imm_u_i     (imm_u),
        .imm_j_i     (imm_j),
        .pc_mode_i   (pc_mode),
        .op1_sel_i   (op1_sel),
        .op2_sel_i   (op2_sel),
        .wb_addr_i   (wb_addr_i),
        .wb_data_i   (wb_data_i),
        .wb_valid_i  (wb_valid_i),
        .alu_op1_o   (alu_op1),
        .alu_op2_o   (alu_op2),
        .rs2_val_o   (rs2_val),
        .jmp_addr_o  (jmp_addr_o),
        .jmp_valid_o (jmp_valid_o)
    );

    id_output_reg u_out_reg (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .valid_i    (valid_i),
        .stall_i    (stall_i),
        .pc_i       (pc_i),
        .ir_i       (ir_i),
        .rd_i       (rd),
        .illegal_i  (illegal),
        .alu_op1_i  (alu_op1),
        .alu_op2_i  (alu_op2),
        .rs2_val_i  (rs2_val),
        .alu_mode_i (alu_mode),
        .ma_mode_i  (ma_mode),
        .ma_size_i  (ma_size),
        .wb_src_i   (wb_src),
        .pc_o       (pc_o),
        .ir_o       (ir_o),
        .alu_op1_o  (alu_op1_o),
        .alu_op2_o  (alu_op2_o),
        .alu_mode_o (alu_mode_o),
        .ma_mode_o  (ma_mode_o),
        .ma_size_o  (ma_size_o),
        .ma_data_o  (ma_data_o),
        .wb_src_o   (wb_src_o),
        .wb_pc4_o   (wb_pc4_o),
        .wb_valid_o (wb_valid_o),
        .halt_o     (halt_o)
    );

endmodule

// File: verif/id_stage_props.sv
`timescale 1ns/10ps

module id_stage_props
    import id_stage_pkg::*;
    (
        input logic  clk_i,
        input logic  reset_i,
        input logic  valid_i,
        input logic  stall_i,
        input logic  jmp_valid_i,
        input logic  halt_i,
        input word_t pc_i,
        input word_t ir_i,
        input word_t alu_op1_i,
        input word_t alu_op2_i,
        input word_t ma_data_i
    );

    halt_low_after_reset: assert property (@(posedge clk_i) $fell(reset_i) |-> !halt_i)
        else $error("halt_o high in the first cycle after reset");

    // no redirect without an instruction
    jump_needs_valid: assert property (@(posedge clk_i) jmp_valid_i |-> valid_i)
        else $error("jmp_valid_o high while valid_i is low");

    hold_on_stall: assert property (@(posedge clk_i) (stall_i && !reset_i) |=>
        $stable({pc_i, ir_i, alu_op1_i, alu_op2_i, ma_data_i, halt_i}))
        else $error("registered outputs changed under stall_i");

endmodule

bind id_stage id_stage_props u_props (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (valid_i),
    .stall_i     (stall_i),
    .jmp_valid_i (jmp_valid_o),
    .halt_i      (halt_o),
    .pc_i        (pc_o),
    .ir_i        (ir_o),
    .alu_op1_i   (alu_op1_o),
    .alu_op2_i   (alu_op2_o),
    .ma_data_i   (ma_data_o)
);

// File: verif/id_stage_checker.sv
`timescale 1ns/10ps

module id_stage_checker
    import id_stage_pkg::*;
    (
        input  logic      clk_i,
        input  logic      row_active_i,
        input  int        row_idx_i,
        input  logic      reg_active_i,
        input  int        reg_idx_i,
        input  int        n_rows_i,
        input  logic      exp_jmp_valid_i,
        input  word_t     exp_jmp_addr_i,
        input  logic      exp_ready_i,
        input  word_t     exp_ir_i,
        input  word_t     exp_pc_i,
        input  word_t     exp_pc4_i,
        input  word_t     exp_op1_i,
        input  word_t     exp_op2_i,
        input  alu_mode_t exp_alu_mode_i,
        input  word_t     exp_ma_data_i,
        input  ma_mode_t  exp_ma_mode_i,
        input  ma_size_t  exp_ma_size_i,
        input  wb_src_t   exp_wb_src_i,
        input  logic      exp_wb_valid_i,
        input  logic      exp_halt_i,
        input  logic      jmp_valid_i,
        input  word_t     jmp_addr_i,
        input  logic      ready_i,
        input  word_t     ir_i,
        input  word_t     pc_i,
        input  word_t     wb_pc4_i,
        input  word_t     alu_op1_i,
        input  word_t     alu_op2_i,
        input  alu_mode_t alu_mode_i,
        input  word_t     ma_data_i,
        input  ma_mode_t  ma_mode_i,
        input  ma_size_t  ma_size_i,
        input  wb_src_t   wb_src_i,
        input  logic      wb_valid_i,
        input  logic      halt_i,
        output int        pass_count_o,
        output int        fail_count_o,
        output logic      done_o
    );

    int   passes    = 0;
    int   fails     = 0;
    int   comb_errs = 0; // drive-cycle mismatches of the row in decode
    logic finished  = 1'b0;

    assign pass_count_o = passes;
    assign fail_count_o = fails;
    assign done_o       = finished;

    function automatic int mismatch(int row, string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("FAIL row %0d %s: got %h expected %h", row, name, got, exp);
            return 1;
        end
        return 0;
    endfunction

    // falling edge, all drives and register updates settled
    always @(negedge clk_i) begin
        int errs;
        errs = 0;
        if (reg_active_i) begin
            errs = comb_errs;
            errs += mismatch(reg_idx_i, "pc_o", pc_i, exp_pc_i);
            errs += mismatch(reg_idx_i, "ir_o", ir_i, exp_ir_i);
            errs += mismatch(reg_idx_i, "alu_op1_o", alu_op1_i, exp_op1_i);
            errs += mismatch(reg_idx_i, "alu_op2_o", alu_op2_i, exp_op2_i);
            errs += mismatch(reg_idx_i, "alu_mode_o", 32'(alu_mode_i), 32'(exp_alu_mode_i));
            errs += mismatch(reg_idx_i, "ma_data_o", ma_data_i, exp_ma_data_i);
            errs += mismatch(reg_idx_i, "ma_mode_o", 32'(ma_mode_i), 32'(exp_ma_mode_i));
            errs += mismatch(reg_idx_i, "ma_size_o", 32'(ma_size_i), 32'(exp_ma_size_i));
            errs += mismatch(reg_idx_i, "wb_src_o", 32'(wb_src_i), 32'(exp_wb_src_i));
            errs += mismatch(reg_idx_i, "wb_pc4_o", wb_pc4_i, exp_pc4_i);
            errs += mismatch(reg_idx_i, "wb_valid_o", 32'(wb_valid_i), 32'(exp_wb_valid_i));
            errs += mismatch(reg_idx_i, "halt_o", 32'(halt_i), 32'(exp_halt_i));
            if (errs == 0) begin
                passes++;
                $display("PASS row %0d", reg_idx_i);
            end else begin
                fails++;
                $display("FAIL row %0d: %0d mismatches", reg_idx_i, errs);
            end
            if (reg_idx_i == n_rows_i - 1) begin
                $display("rows %0d, passed %0d, failed %0d", n_rows_i, passes, fails);
                finished = 1'b1;
            end
        end
        // jump and ready outputs are combinational, checked in the drive cycle
        if (row_active_i) begin
            comb_errs = mismatch(row_idx_i, "jmp_valid_o", 32'(jmp_valid_i),
                                 32'(exp_jmp_valid_i));
            if (exp_jmp_valid_i) begin
                comb_errs += mismatch(row_idx_i, "jmp_addr_o", jmp_addr_i, exp_jmp_addr_i);
            end
            comb_errs += mismatch(row_idx_i, "ready_o", 32'(ready_i), 32'(exp_ready_i));
        end
    end

endmodule

// File: verif/id_stage_tb.sv
`timescale 1ns/10ps
`include "id_stage_consts.svh"

module id_stage_tb
    import id_stage_pkg::*;
    ();

    localparam int NROWS          = 22;
    localparam int TIMEOUT_CYCLES = NROWS + 5 + 20;

    // one table row: stimulus, then expected results
    typedef struct packed {
        word_t     pc;
        word_t     ir;
        logic      valid;
        logic      stall;
        regaddr_t  wb_addr;
        word_t     wb_data;
        logic      wb_valid;
        word_t     op1;
        word_t     op2;
        word_t     ma_data;
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        word_t     ir_out;
        word_t     pc_out;
        word_t     pc4;
        alu_mode_t alu_mode;
        wb_src_t   wb_src;
        logic      wb_out; // expected wb_valid_o
        logic      halt;
        logic      jmp_valid;
        word_t     jmp_addr;
    } row_t;

    logic     clk;
    logic     reset;
    word_t    pc;
    word_t    ir;
    logic     valid;
    regaddr_t wb_addr;
    word_t    wb_data;
    logic     wb_valid;
    logic     stall;
    logic     ready;
    word_t    jmp_addr;
    logic     jmp_valid;
    word_t    pc_out;
    word_t    ir_out;
    word_t    alu_op1;
    word_t    alu_op2;
    alu_mode_t alu_mode;
    ma_mode_t ma_mode;
    ma_size_t ma_size;
    word_t    ma_data;
    wb_src_t  wb_src;
    word_t    wb_pc4;
    logic     wb_valid_out;
    logic     halt;

    row_t   rows [NROWS];
    int     row_idx    = 0;
    logic   row_active = 1'b0;
    int     reg_idx    = 0; // row whose result sits in the output register
    logic   reg_active = 1'b0;
    int     cycles     = 0;
    int     pass_count;
    int     fail_count;
    logic   checks_done;
    integer seed;
    word_t  d1, d2, d3;

    // instruction encoders
    function automatic word_t add_instr(regaddr_t rd, regaddr_t rs1, regaddr_t rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, `OP_OP};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, regaddr_t rs1, funct3_t f3,
                                     regaddr_t rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, regaddr_t rs2, regaddr_t rs1,
                                     funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
    endfunction

    function automatic word_t b_type(logic [12:0] imm, regaddr_t rs2, regaddr_t rs1,
                                     funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic word_t j_type(logic [20:0] imm, regaddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    // valid instruction, no write-back, no memory access, no jump
    function automatic row_t instr_row(word_t pc_v, word_t ir_v, word_t op1_v,
                                       word_t op2_v, word_t data_v);
        row_t r;
        r         = '0;
        r.pc      = pc_v;
        r.ir      = ir_v;
        r.valid   = 1'b1;
        r.op1     = op1_v;
        r.op2     = op2_v;
        r.ma_data = data_v;
        r.ir_out  = ir_v;
        r.pc_out  = pc_v;
        r.pc4     = pc_v + 32'd4;
        return r;
    endfunction

    // no instruction, so a bubble one cycle later
    function automatic row_t idle_row(regaddr_t a, word_t d, logic v);
        row_t r;
        r          = '0;
        r.wb_addr  = a;
        r.wb_data  = d;
        r.wb_valid = v;
        r.ir_out   = `NOP_IR;
        r.pc_out   = `NOP_PC;
        return r;
    endfunction

    id_stage dut0 (
        .clk_i       (clk),
        .reset_i     (reset),
        .pc_i        (pc),
        .ir_i        (ir),
        .valid_i     (valid),
        .wb_addr_i   (wb_addr),
        .wb_data_i   (wb_data),
        .wb_valid_i  (wb_valid),
        .stall_i     (stall),
        .ready_o     (ready),
        .jmp_addr_o  (jmp_addr),
        .jmp_valid_o (jmp_valid),
        .pc_o        (pc_out),
        .ir_o        (ir_out),
        .alu_op1_o   (alu_op1),
        .alu_op2_o   (alu_op2),
        .alu_mode_o  (alu_mode),
        .ma_mode_o   (ma_mode),
        .ma_size_o   (ma_size),
        .ma_data_o   (ma_data),
        .wb_src_o    (wb_src),
        .wb_pc4_o    (wb_pc4),
        .wb_valid_o  (wb_valid_out),
        .halt_o      (halt)
    );

    id_stage_checker checker0 (
        .clk_i           (clk),
        .row_active_i    (row_active),
        .row_idx_i       (row_idx),
        .reg_active_i    (reg_active),
        .reg_idx_i       (reg_idx),
        .n_rows_i        (NROWS),
        .exp_jmp_valid_i (rows[row_idx].jmp_valid),
        .exp_jmp_addr_i  (rows[row_idx].jmp_addr),
        .exp_ready_i     (!rows[row_idx].stall),
        .exp_ir_i        (rows[reg_idx].ir_out),
        .exp_pc_i        (rows[reg_idx].pc_out),
        .exp_pc4_i       (rows[reg_idx].pc4),
        .exp_op1_i       (rows[reg_idx].op1),
        .exp_op2_i       (rows[reg_idx].op2),
        .exp_alu_mode_i  (rows[reg_idx].alu_mode),
        .exp_ma_data_i   (rows[reg_idx].ma_data),
        .exp_ma_mode_i   (rows[reg_idx].ma_mode),
        .exp_ma_size_i   (rows[reg_idx].ma_size),
        .exp_wb_src_i    (rows[reg_idx].wb_src),
        .exp_wb_valid_i  (rows[reg_idx].wb_out),
        .exp_halt_i      (rows[reg_idx].halt),
        .jmp_valid_i     (jmp_valid),
        .jmp_addr_i      (jmp_addr),
        .ready_i         (ready),
        .ir_i            (ir_out),
        .pc_i            (pc_out),
        .wb_pc4_i        (wb_pc4),
        .alu_op1_i       (alu_op1),
        .alu_op2_i       (alu_op2),
        .alu_mode_i      (alu_mode),
        .ma_data_i       (ma_data),
        .ma_mode_i       (ma_mode),
        .ma_size_i       (ma_size),
        .wb_src_i        (wb_src),
        .wb_valid_i      (wb_valid_out),
        .halt_i          (halt),
        .pass_count_o    (pass_count),
        .fail_count_o    (fail_count),
        .done_o          (checks_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // results show up one edge after the row is driven
    always @(posedge clk) begin
        reg_idx    <= row_idx;
        reg_active <= row_active;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        seed = 32'h401c1577;
        d1   = $random(seed);
        d2   = $random(seed);
        d3   = $random(seed);

        rows[0] = idle_row(5'd0, '0, 1'b0);
        rows[1] = idle_row(5'd1, d1, 1'b1);
        rows[2] = idle_row(5'd2, d2, 1'b1);
        rows[3] = idle_row(5'd4, 32'hffff_fff0, 1'b1);
        rows[4] = idle_row(5'd5, 32'd5, 1'b1);
        // addi x6, x1, -128
        rows[5] = instr_row(32'h100, i_type(12'hf80, 5'd1, 3'b000, 5'd6, `OP_IMM),
                            d1, 32'hffff_ff80, '0);
        rows[5].wb_src = WB_ALU;
        rows[5].wb_out = 1'b1;
        rows[6] = instr_row(32'h104, add_instr(5'd7, 5'd1, 5'd2), d1, d2, d2);
        rows[6].wb_src = WB_ALU;
        rows[6].wb_out = 1'b1;
        rows[7] = instr_row(32'h108, add_instr(5'd8, 5'd0, 5'd2), '0, d2, d2); // x0 reads zero
        rows[7].wb_src = WB_ALU;
        rows[7].wb_out = 1'b1;
        // x3 arrives on the write-back port in the same cycle
        rows[8] = instr_row(32'h10c, add_instr(5'd9, 5'd3, 5'd1), d3, d1, d1);
        rows[8].wb_addr  = 5'd3;
        rows[8].wb_data  = d3;
        rows[8].wb_valid = 1'b1;
        rows[8].wb_src   = WB_ALU;
        rows[8].wb_out   = 1'b1;
        // jal x0, +0x100
        rows[9] = instr_row(32'h1000, j_type(21'h100, 5'd0), '0, '0, '0);
        rows[9].jmp_valid = 1'b1;
        rows[9].jmp_addr  = 32'h1100;
        rows[9].wb_src    = WB_PC4; // rd is x0, so no write-back
        // jalr x0, 0x40(x1)
        rows[10] = instr_row(32'h1004, i_type(12'h040, 5'd1, 3'b000, 5'd0, `OP_JALR),
                             '0, '0, '0);
        rows[10].jmp_valid = 1'b1;
        rows[10].jmp_addr  = d1 + 32'h40;
        rows[10].wb_src    = WB_PC4;
        rows[11] = instr_row(32'h2000, b_type(13'h020, 5'd1, 5'd1, `F3_BEQ), '0, '0, d1);
        rows[11].jmp_valid = 1'b1;
        rows[11].jmp_addr  = 32'h2020;
        rows[12] = instr_row(32'h2004, b_type(13'h020, 5'd1, 5'd1, `F3_BNE), '0, '0, d1);
        // x4 is negative signed but large unsigned
        rows[13] = instr_row(32'h3000, b_type(13'h1ff8, 5'd5, 5'd4, `F3_BLT), '0, '0, 32'd5);
        rows[13].jmp_valid = 1'b1;
        rows[13].jmp_addr  = 32'h2ff8;
        rows[14] = instr_row(32'h3004, b_type(13'h010, 5'd5, 5'd4, `F3_BGE), '0, '0, 32'd5);
        rows[15] = instr_row(32'h3008, b_type(13'h010, 5'd5, 5'd4, `F3_BLTU), '0, '0, 32'd5);
        rows[16] = instr_row(32'h300c, b_type(13'h010, 5'd5, 5'd4, `F3_BGEU), '0, '0, 32'd5);
        rows[16].jmp_valid = 1'b1;
        rows[16].jmp_addr  = 32'h301c;
        // lw x10, 0x40(x1)
        rows[17] = instr_row(32'h400, i_type(12'h040, 5'd1, 3'b010, 5'd10, `OP_LOAD),
                             d1, 32'h40, '0);
        rows[17].ma_mode = MA_LOAD;
        rows[17].ma_size = 3'b010;
        rows[17].wb_src  = WB_MEM;
        rows[17].wb_out  = 1'b1;
        // sh x2, -4(x1)
        rows[18] = instr_row(32'h404, s_type(12'hffc, 5'd2, 5'd1, 3'b001),
                             d1, 32'hffff_fffc, d2);
        rows[18].ma_mode = MA_STORE;
        rows[18].ma_size = 3'b001;
        rows[19] = instr_row(32'h408, 32'h0000_007f, '0, '0, '0); // unknown opcode
        rows[19].halt = 1'b1;
        // stalled add, outputs keep the previous row
        rows[20]       = rows[19];
        rows[20].pc    = 32'h40c;
        rows[20].ir    = add_instr(5'd7, 5'd1, 5'd2);
        rows[20].stall = 1'b1;
        // a jal without valid_i must not redirect
        rows[21]    = idle_row(5'd0, '0, 1'b0);
        rows[21].ir = j_type(21'h100, 5'd0);

        reset    = 1'b1;
        pc       = '0;
        ir       = '0; // illegal encoding offered during reset
        valid    = 1'b1;
        wb_addr  = '0;
        wb_data  = '0;
        wb_valid = 1'b0;
        stall    = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        valid <= 1'b0;

        for (int i = 0; i < NROWS; i++) begin
            @(posedge clk);
            pc         <= rows[i].pc;
            ir         <= rows[i].ir;
            valid      <= rows[i].valid;
            stall      <= rows[i].stall;
            wb_addr    <= rows[i].wb_addr;
            wb_data    <= rows[i].wb_data;
            wb_valid   <= rows[i].wb_valid;
            row_idx    <= i;
            row_active <= 1'b1;
        end
        @(posedge clk);
        valid      <= 1'b0;
        stall      <= 1'b0;
        wb_valid   <= 1'b0;
        row_active <= 1'b0;

        while (!checks_done) begin
            @(posedge clk);
        end
        if (fail_count == 0 && pass_count == NROWS) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: id_stage.f
+incdir+common
common/id_stage_pkg.sv
decode/instr_decoder.sv
verilog/regfile.sv
verilog/operand_unit.sv
verilog/id_output_reg.sv
verilog/id_stage.sv
verif/id_stage_props.sv
verif/id_stage_checker.sv
verif/id_stage_tb.sv

// File: Makefile
LOG = sim.log

sim:
	verilator --binary --timing --assert --top-module id_stage_tb -f id_stage.f -o id_stage_sim
	./obj_dir/id_stage_sim | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
